/* vlog.f */
+incdir+include
hdl/dehaze_pkg.sv
hdl/transmission_estimator.sv
hdl/record_fifo.sv
hdl/scene_recovery.sv
hdl/dehaze_top.sv
verification/dehaze_tb.sv

/* Makefile */
# Verilator build and run of the haze-removal testbench

VERILATOR ?= verilator
TOP       ?= dehaze_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_TEXT ?= TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* include/dehaze_model.svh */
// Bit-exact software model of the datapath; needs dehaze_pkg compiled first
`ifndef DEHAZE_MODEL_SVH
`define DEHAZE_MODEL_SVH

// Channel 0 is red, 2 is blue
function automatic int model_chan(input dehaze_pkg::pixel_t p, input int ch);
    int v;
    case (ch)
        0:       v = p.red;
        1:       v = p.green;
        default: v = p.blue;
    endcase
    return v;
endfunction

function automatic int model_mean(input dehaze_pkg::pixel_t win [dehaze_pkg::WIN_N], input int ch);
    int sum;
    sum = 0;
    for (int i = 0; i < dehaze_pkg::WIN_N; i++) begin
        sum += model_chan(win[i], ch);
    end
    return (sum * dehaze_pkg::MEAN_MUL) >>> dehaze_pkg::MEAN_SHIFT;
endfunction

// ==============================
// Transmission and reciprocal
// ==============================
function automatic int model_trans(
    input dehaze_pkg::pixel_t win [dehaze_pkg::WIN_N],
    input dehaze_pkg::q16_t   inv [3]
);
    int m [3];
    int sel;
    int sinv;
    int ratio;
    int t;
    for (int c = 0; c < 3; c++) begin
        m[c] = model_mean(win, c);
    end
    // Strict compare keeps red, then green, on ties
    sel = 0;
    if (m[1] < m[sel]) sel = 1;
    if (m[2] < m[sel]) sel = 2;
    sinv  = inv[sel] - (inv[sel] >> dehaze_pkg::OMEGA_SHIFT);
    ratio = m[sel] * sinv;
    if (ratio > 65535) ratio = 65535;
    t = 65535 - ratio;
    if (t < dehaze_pkg::T_MIN) t = dehaze_pkg::T_MIN;
    return t;
endfunction

function automatic int model_recover(input int a, input int i, input int recip);
    int d;
    int off;
    int j;
    d   = (i > a) ? i - a : a - i;
    off = (d * recip) >>> dehaze_pkg::RECIP_SHIFT;
    if (off > 255) off = 255;
    j = (i < a) ? a - off : a + off;
    if (j < 0) j = 0;
    if (j > 255) j = 255;
    return j;
endfunction

function automatic dehaze_pkg::pixel_t model_expected(
    input dehaze_pkg::pixel_t win [dehaze_pkg::WIN_N],
    input dehaze_pkg::pixel_t atm,
    input dehaze_pkg::q16_t   inv [3]
);
    dehaze_pkg::pixel_t ctr;
    dehaze_pkg::pixel_t res;
    int recip;
    ctr   = win[dehaze_pkg::CENTER_IDX];
    recip = (1 << dehaze_pkg::RECIP_BITS) / model_trans(win, inv);
    res.red   = 8'(model_recover(atm.red, ctr.red, recip));
    res.green = 8'(model_recover(atm.green, ctr.green, recip));
    res.blue  = 8'(model_recover(atm.blue, ctr.blue, recip));
    return res;
endfunction

`endif

/* verification/dehaze_tb.sv */
// Table-driven check of dehaze_top; A channels must be nonzero so the inverses fit 16 bits
`timescale 1ns/1ns

module dehaze_tb
    import dehaze_pkg::*;
();

    `include "dehaze_model.svh"

    localparam int          NUM_TESTS      = 20;
    localparam int          NUM_FIXED      = 9;
    localparam logic [31:0] SEED           = 32'h6537;
    localparam int          TIMEOUT_MARGIN = 200;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * (DIV_CYCLES + 6) * 3 + TIMEOUT_MARGIN;

    logic   clk;
    logic   rst;
    logic   in_valid;
    logic   in_ready;
    pixel_t window [WIN_N];
    pixel_t atm;
    q16_t   atm_inv [3];
    logic   out_valid;
    logic   out_ready;
    pixel_t out_pixel;

    // Stimulus table with expected pixels
    string  tbl_name [NUM_TESTS];
    pixel_t tbl_win  [NUM_TESTS][WIN_N];
    pixel_t tbl_atm  [NUM_TESTS];
    q16_t   tbl_inv  [NUM_TESTS][3];
    pixel_t tbl_exp  [NUM_TESTS];

    logic [31:0] lfsr_state;
    int          cycles;
    int          passed;
    int          errors;

    dehaze_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .window    (window),
        .atm       (atm),
        .atm_inv   (atm_inv),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel)
    );

    always begin
        #5 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic pixel_t make_pixel(input int r, input int g, input int b);
        pixel_t p;
        p.red   = 8'(r);
        p.green = 8'(g);
        p.blue  = 8'(b);
        return p;
    endfunction

    // floor(65536 / a), limited to 16 bits
    function automatic q16_t inverse_of(input channel_t a);
        int v;
        v = 65536 / ((a == 0) ? 1 : int'(a));
        if (v > 65535) v = 65535;
        return q16_t'(v);
    endfunction

    task automatic finish_entry(input int idx, input string name, input pixel_t a);
        pixel_t w [WIN_N];
        q16_t   inv [3];
        inv[0] = inverse_of(a.red);
        inv[1] = inverse_of(a.green);
        inv[2] = inverse_of(a.blue);
        tbl_name[idx] = name;
        tbl_atm[idx]  = a;
        tbl_inv[idx]  = inv;
        w = tbl_win[idx];
        tbl_exp[idx] = model_expected(w, a, inv);
    endtask

    task automatic set_uniform(input int idx, input string name, input pixel_t fill,
                               input pixel_t center, input pixel_t a);
        for (int i = 0; i < WIN_N; i++) begin
            tbl_win[idx][i] = fill;
        end
        tbl_win[idx][CENTER_IDX] = center;
        finish_entry(idx, name, a);
    endtask

    task automatic set_random(input int idx);
        logic [23:0] bits;
        for (int i = 0; i < WIN_N; i++) begin
            bits = 24'(random_bits(24));
            tbl_win[idx][i] = pixel_t'(bits);
        end
        // Keep A away from zero
        bits = 24'(random_bits(24)) | 24'h202020;
        finish_entry(idx, $sformatf("random_%0d", idx), pixel_t'(bits));
    endtask

    task automatic build_table();
        set_uniform(0, "grey_uniform", make_pixel(128, 128, 128), make_pixel(128, 128, 128),
                    make_pixel(200, 200, 200));
        set_uniform(1, "tie_all_red", make_pixel(100, 100, 100), make_pixel(100, 100, 100),
                    make_pixel(220, 180, 240));
        set_uniform(2, "dark_red", make_pixel(40, 120, 160), make_pixel(60, 100, 180),
                    make_pixel(200, 210, 220));
        set_uniform(3, "dark_green", make_pixel(150, 30, 140), make_pixel(140, 50, 130),
                    make_pixel(230, 190, 210));
        set_uniform(4, "dark_blue", make_pixel(150, 140, 20), make_pixel(160, 120, 40),
                    make_pixel(210, 220, 180));
        set_uniform(5, "tie_green_blue", make_pixel(200, 60, 60), make_pixel(190, 70, 70),
                    make_pixel(240, 150, 230));
        // Mean above A saturates the ratio
        // Center near A keeps the offset below its limit
        set_uniform(6, "clamp_tmin", make_pixel(250, 250, 250), make_pixel(70, 66, 64),
                    make_pixel(60, 60, 60));
        set_uniform(7, "clamp_low", make_pixel(240, 240, 240), make_pixel(5, 5, 5),
                    make_pixel(250, 250, 250));
        set_uniform(8, "clamp_high", make_pixel(230, 230, 230), make_pixel(250, 245, 240),
                    make_pixel(100, 120, 110));
        for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
            set_random(i);
        end
    endtask

    // ==============================
    // Drive and receive
    // ==============================

    // in_ready only changes on a rising edge, so the falling-edge sample is safe
    task automatic send_all();
        logic accepted;
        for (int i = 0; i < NUM_TESTS; i++) begin
            window   = tbl_win[i];
            atm      = tbl_atm[i];
            atm_inv  = tbl_inv[i];
            in_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                accepted = in_ready;
                @(negedge clk);
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic check_result(input int idx);
        if (out_pixel !== tbl_exp[idx]) begin
            errors++;
            $display("Error: %s expected %06h actual %06h", tbl_name[idx], tbl_exp[idx],
                     out_pixel);
        end else begin
            passed++;
            $display("Pass: %s = %06h", tbl_name[idx], out_pixel);
        end
    endtask

    task automatic receive_all();
        int count;
        count = 0;
        while (count < NUM_TESTS) begin
            @(negedge clk);
            out_ready = random_bits(1) != 0;
            if (out_valid && out_ready) begin
                check_result(count);
                count++;
            end
        end
    endtask

    // Nothing more may come out once every result is in
    task automatic check_idle();
        out_ready = 1'b1;
        for (int i = 0; i < DIV_CYCLES + 10; i++) begin
            @(negedge clk);
            if (out_valid) begin
                errors++;
                $display("An extra result appeared after all tests were received");
                break;
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        atm        = '0;
        atm_inv[0] = '0;
        atm_inv[1] = '0;
        atm_inv[2] = '0;
        for (int i = 0; i < WIN_N; i++) begin
            window[i] = '0;
        end
        lfsr_state = SEED;
        cycles     = 0;
        passed     = 0;
        errors     = 0;
        build_table();

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            errors++;
            $display("Reset check failed because out_valid is high before any input");
        end
        if (in_ready !== 1'b1) begin
            errors++;
            $display("Reset check failed because in_ready is low after reset");
        end

        fork
            send_all();
            receive_all();
        join
        check_idle();

        $display("Summary: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with results still missing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* hdl/dehaze_top.sv */
// Results leave in input order; latency depends on FIFO occupancy and out_ready
`timescale 1ns/1ns

module dehaze_top
    import dehaze_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    output logic   in_ready,
    input  pixel_t window [WIN_N],
    input  pixel_t atm,
    input  q16_t   atm_inv [3],
    output logic   out_valid,
    input  logic   out_ready,
    output pixel_t out_pixel
);

    // Estimator to FIFO
    logic      est_valid;
    logic      est_ready;
    haze_rec_t est_rec;

    // FIFO to recovery
    logic      buf_valid;
    logic      buf_ready;
    haze_rec_t buf_rec;

    transmission_estimator est0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .window    (window),
        .atm       (atm),
        .atm_inv   (atm_inv),
        .est_valid (est_valid),
        .est_ready (est_ready),
        .est_rec   (est_rec)
    );

    record_fifo #(
        .T     (haze_rec_t),
        .DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (est_valid),
        .in_ready  (est_ready),
        .in_data   (est_rec),
        .out_valid (buf_valid),
        .out_ready (buf_ready),
        .out_data  (buf_rec)
    );

    scene_recovery rec0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (buf_valid),
        .in_ready  (buf_ready),
        .in_rec    (buf_rec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel)
    );

endmodule

/* hdl/scene_recovery.sv */
// One record at a time; trans must be at least T_MIN so the reciprocal fits 16 bits
`timescale 1ns/1ns

module scene_recovery
    import dehaze_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  haze_rec_t in_rec,
    output logic      out_valid,
    input  logic      out_ready,
    output pixel_t    out_pixel
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV,
        ST_HOLD
    } state_t;

    state_t state;

    logic [$clog2(DIV_CYCLES+1)-1:0] cnt_q;

    // Divider state
    logic [Q_W-1:0] rem_q;
    q16_t           quo_q;
    q16_t           trans_q;

    // Per-channel terms captured at accept
    pixel_t     atm_q;
    pixel_t     diff_q;
    logic [2:0] below_q;

    // Divider step
    logic           div_bit;
    logic [Q_W:0]   rem_sh;
    logic [Q_W:0]   rem_sub;
    logic           ge;
    logic [Q_W-1:0] rem_nx;
    q16_t           quo_nx;

    pixel_t rec_pix;

    function automatic channel_t abs_diff(input channel_t a, input channel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // A +/- |I-A|/t with saturation at both ends
    function automatic channel_t recover_ch(
        input channel_t a,
        input channel_t d,
        input logic     below,
        input q16_t     recip
    );
        logic [CH_W+Q_W-1:0] prod;
        logic [CH_W+Q_W-1:0] off;
        channel_t            mag;
        logic [CH_W:0]       sum;
        channel_t            res;
        prod = d * recip;
        off  = prod >> RECIP_SHIFT;
        mag  = (|off[CH_W+Q_W-1:CH_W]) ? '1 : off[CH_W-1:0];
        sum  = {1'b0, a} + {1'b0, mag};
        if (below) begin
            res = (mag > a) ? '0 : a - mag;
        end else begin
            res = sum[CH_W] ? '1 : sum[CH_W-1:0];
        end
        return res;
    endfunction

    // ==============================
    // Restoring divider, 2^24 / t
    // ==============================

    // Dividend has a single one, at its top bit
    assign div_bit = (DIV_CYCLES - 1 - int'(cnt_q)) == RECIP_BITS;
    assign rem_sh  = {rem_q, div_bit};
    assign rem_sub = rem_sh - {1'b0, trans_q};
    assign ge      = rem_sh >= {1'b0, trans_q};
    assign rem_nx  = ge ? rem_sub[Q_W-1:0] : rem_sh[Q_W-1:0];
    assign quo_nx  = {quo_q[Q_W-2:0], ge};

    // Recovery math reads the finished quotient
    assign rec_pix.red   = recover_ch(atm_q.red, diff_q.red, below_q[2], quo_q);
    assign rec_pix.green = recover_ch(atm_q.green, diff_q.green, below_q[1], quo_q);
    assign rec_pix.blue  = recover_ch(atm_q.blue, diff_q.blue, below_q[0], quo_q);

    // ==============================
    // Controller
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        state <= ST_DIV;
                        cnt_q <= '0;
                    end
                end
                ST_DIV: begin
                    // Last count loads the output register
                    if (cnt_q == DIV_CYCLES) begin
                        state <= ST_HOLD;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (out_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && in_valid) begin
            trans_q    <= in_rec.trans;
            atm_q      <= in_rec.atm;
            rem_q      <= '0;
            quo_q      <= '0;
            diff_q.red   <= abs_diff(in_rec.center.red, in_rec.atm.red);
            diff_q.green <= abs_diff(in_rec.center.green, in_rec.atm.green);
            diff_q.blue  <= abs_diff(in_rec.center.blue, in_rec.atm.blue);
            below_q[2] <= in_rec.center.red < in_rec.atm.red;
            below_q[1] <= in_rec.center.green < in_rec.atm.green;
            below_q[0] <= in_rec.center.blue < in_rec.atm.blue;
        end else if (state == ST_DIV) begin
            if (cnt_q == DIV_CYCLES) begin
                out_pixel <= rec_pix;
            end else begin
                rem_q <= rem_nx;
                quo_q <= quo_nx;
            end
        end
    end

    assign in_ready  = state == ST_IDLE;
    assign out_valid = state == ST_HOLD;

endmodule

/* hdl/record_fifo.sv */
// DEPTH must be at least 2; accepts a write while full if a read happens in the same cycle
`timescale 1ns/1ns

module record_fifo
    import dehaze_pkg::*;
#(
    parameter type T     = haze_rec_t,
    parameter int  DEPTH = FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    T mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       wr_en;
    logic                       rd_en;

    assign out_valid = count != 0;
    // Full FIFO still takes a beat when the head leaves
    assign in_ready  = (count != DEPTH) || out_ready;
    assign out_data  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* hdl/transmission_estimator.sv */
// Expects atm_inv as floor(65536 / A) per channel with A nonzero; pipeline freezes on back-pressure
`timescale 1ns/1ns

module transmission_estimator
    import dehaze_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  pixel_t    window [WIN_N],
    input  pixel_t    atm,
    input  q16_t      atm_inv [3],
    output logic      est_valid,
    input  logic      est_ready,
    output haze_rec_t est_rec
);

    // All three stages move together
    logic advance;

    // Stage 1 registers
    logic     v1;
    channel_t mean1_r;
    channel_t mean1_g;
    channel_t mean1_b;
    pixel_t   center1;
    pixel_t   atm1;
    q16_t     inv1 [3];

    // Stage 2 registers
    logic     v2;
    channel_t dark2;
    q16_t     sinv2;
    pixel_t   center2;
    pixel_t   atm2;

    // Stage 3 registers
    logic      v3;
    haze_rec_t rec3;

    // Combinational terms
    logic [CH_W+3:0]     sum_r;
    logic [CH_W+3:0]     sum_g;
    logic [CH_W+3:0]     sum_b;
    channel_t            dark_mean;
    q16_t                dark_inv;
    q16_t                scaled_inv;
    logic [CH_W+Q_W-1:0] prod;
    q16_t                ratio;
    q16_t                t_raw;
    q16_t                t_clamped;

    // Approximate division by nine
    function automatic channel_t mean_of(input logic [CH_W+3:0] sum);
        logic [CH_W+9:0] scaled;
        scaled = sum * (CH_W+10)'(MEAN_MUL);
        return channel_t'(scaled >> MEAN_SHIFT);
    endfunction

    assign advance  = !v3 || est_ready;
    assign in_ready = advance;

    // ==============================
    // Stage 1: channel sums
    // ==============================
    always_comb begin
        sum_r = '0;
        sum_g = '0;
        sum_b = '0;
        for (int i = 0; i < WIN_N; i++) begin
            sum_r = sum_r + window[i].red;
            sum_g = sum_g + window[i].green;
            sum_b = sum_b + window[i].blue;
        end
    end

    // ==============================
    // Stage 2: darkest channel
    // ==============================

    // Ties go to red, then green
    always_comb begin
        if (mean1_r <= mean1_g && mean1_r <= mean1_b) begin
            dark_mean = mean1_r;
            dark_inv  = inv1[0];
        end else if (mean1_g <= mean1_b) begin
            dark_mean = mean1_g;
            dark_inv  = inv1[1];
        end else begin
            dark_mean = mean1_b;
            dark_inv  = inv1[2];
        end
    end

    assign scaled_inv = dark_inv - (dark_inv >> OMEGA_SHIFT);

    // ==============================
    // Stage 3: transmission
    // ==============================

    // Ratio mean/A lands in Q0.16; saturates when the mean exceeds A
    assign prod      = dark2 * sinv2;
    assign ratio     = (|prod[CH_W+Q_W-1:Q_W]) ? '1 : prod[Q_W-1:0];
    assign t_raw     = {Q_W{1'b1}} - ratio;
    assign t_clamped = (t_raw < q16_t'(T_MIN)) ? q16_t'(T_MIN) : t_raw;

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (advance) begin
            v1 <= in_valid;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (advance) begin
            mean1_r <= mean_of(sum_r);
            mean1_g <= mean_of(sum_g);
            mean1_b <= mean_of(sum_b);
            center1 <= window[CENTER_IDX];
            atm1    <= atm;
            inv1    <= atm_inv;

            dark2   <= dark_mean;
            sinv2   <= scaled_inv;
            center2 <= center1;
            atm2    <= atm1;

            rec3.center <= center2;
            rec3.atm    <= atm2;
            rec3.trans  <= t_clamped;
        end
    end

    assign est_valid = v3;
    assign est_rec   = rec3;

endmodule

/* hdl/dehaze_pkg.sv */
// Fixed-point formats assume 8-bit RGB channels and Q0.16 fractions for transmission and 1/A
package dehaze_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int CH_W       = 8;
    localparam int Q_W        = 16;
    localparam int WIN_N      = 9;
    localparam int CENTER_IDX = 4;

    // ==============================
    // Fixed-point constants
    // ==============================

    // Mean of nine values as (sum * 57) >> 9
    localparam int MEAN_MUL   = 57;
    localparam int MEAN_SHIFT = 9;

    // Omega of 15/16, applied as inv - (inv >> 4)
    localparam int OMEGA_SHIFT = 4;

    // Lower bound on transmission, about 0.1 in Q0.16
    localparam int T_MIN = 6554;

    // Reciprocal is floor(2^24 / t), kept to 16 bits since t >= T_MIN
    localparam int RECIP_BITS  = 24;
    localparam int RECIP_SHIFT = 8;

    // One iteration per dividend bit
    localparam int DIV_CYCLES = 25;

    localparam int FIFO_DEPTH = 4;

    // ==============================
    // Types
    // ==============================
    typedef logic [CH_W-1:0] channel_t;

    // Red sits in the top byte
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_t;

    typedef logic [Q_W-1:0] q16_t;

    // Record passed from the estimator to the recovery unit
    typedef struct packed {
        pixel_t center;
        pixel_t atm;
        q16_t   trans;
    } haze_rec_t;

endpackage
